/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exec_unit
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu (
        input  logic                        clk_i,
        input  logic                        reset_i,
        alu_req_if.alu                      req,
        output logic                        wr_en_o,
        output logic [4:0]                  wr_addr_o,
        output logic [rv_alu_pkg::XLEN-1:0] wr_data_o
);
        import rv_alu_pkg::*;

        logic            sub_en;
        logic [XLEN-1:0] adder_b;
        logic [XLEN-1:0] sum_result;
        logic            sum_carry;
        logic [XLEN-1:0] xor_result;
        logic            lt_signed;
        logic            lt_unsigned;
        logic [XLEN-1:0] result;
        logic            alu_sel;

        // Compares share the subtractor
        assign sub_en  = req.op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
        assign adder_b = sub_en ? ~req.operand_b : req.operand_b;

        cla_32bit i_cla (
                .term1_i  (req.operand_a),
                .term2_i  (adder_b),
                .carry_i  (sub_en),
                .result_o (sum_result),
                .carry_o  (sum_carry)
        );

        assign xor_result  = req.operand_a ^ req.operand_b;
        assign lt_unsigned = ~sum_carry;                // No carry out means a borrow
        assign lt_signed   = (req.operand_a[XLEN-1] != req.operand_b[XLEN-1]) ?
                             req.operand_a[XLEN-1] : sum_result[XLEN-1];

        always_comb begin
                case (req.op)
                ALU_ADD,
                ALU_SUB:  result = sum_result;
                ALU_SLL:  result = req.operand_a << req.operand_b[4:0];
                ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
                ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
                ALU_XOR:  result = xor_result;
                ALU_SRL:  result = req.operand_a >> req.operand_b[4:0];
                ALU_SRA:  result = $signed(req.operand_a) >>> req.operand_b[4:0];
                ALU_OR:   result = req.operand_a | req.operand_b;
                ALU_AND:  result = req.operand_a & req.operand_b;
                ALU_XNOR: result = ~xor_result;
                ALU_LUI:  result = req.operand_b;       // Upper immediate prepared by decoder
                default:  result = '0;
                endcase
        end

        assign alu_sel = req.valid && (req.unit_sel == UNIT_ALU);

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        wr_en_o   <= 1'b0;
                        wr_addr_o <= '0;
                        wr_data_o <= '0;
                end else begin
                        wr_en_o <= alu_sel;
                        if (alu_sel) begin
                                wr_addr_o <= req.rd;
                                wr_data_o <= result;    // Held for non-ALU instructions
                        end
                end
        end

        // Decoder must only hand over ops the ALU knows
        a_known_op: assert property (@(posedge clk_i) disable iff (reset_i)
                alu_sel |-> req.op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                           ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
                                           ALU_XNOR, ALU_LUI});

endmodule

/* alu_req_if.sv */
`timescale 1ns/1ps

interface alu_req_if;
        import rv_alu_pkg::*;

        logic            valid;                         // One-cycle strobe per instruction
        alu_op_e         op;
        unit_sel_e       unit_sel;
        logic [XLEN-1:0] operand_a;
        logic [XLEN-1:0] operand_b;                     // Immediate already muxed in
        logic [4:0]      rd;

        modport decoder (
                output valid, op, unit_sel, operand_a, operand_b, rd
        );

        modport alu (
                input valid, op, unit_sel, operand_a, operand_b, rd
        );

endinterface

/* cla_32bit.sv */
`timescale 1ns/1ps

module cla_32bit (
        input  logic [rv_alu_pkg::XLEN-1:0] term1_i,
        input  logic [rv_alu_pkg::XLEN-1:0] term2_i,
        input  logic                        carry_i,
        output logic [rv_alu_pkg::XLEN-1:0] result_o,
        output logic                        carry_o
);
        import rv_alu_pkg::*;

        localparam int GRPS = XLEN / 4;

        logic [XLEN-1:0] gen;
        logic [XLEN-1:0] prop;
        logic [GRPS-1:0] grp_gen;
        logic [GRPS-1:0] grp_prop;
        logic [GRPS:0]   grp_carry;
        logic [XLEN-1:0] bit_carry;

        assign gen  = term1_i & term2_i;
        assign prop = term1_i ^ term2_i;

        always_comb begin
                logic acc;
                logic span;
                // Group G/P over four bits
                for (int g = 0; g < GRPS; g++) begin
                        acc  = 1'b0;
                        span = 1'b1;
                        for (int j = 3; j >= 0; j--) begin
                                acc  = acc | (span & gen[4*g+j]);
                                span = span & prop[4*g+j];
                        end
                        grp_gen[g]  = acc;
                        grp_prop[g] = span;
                end
                // Second-level lookahead straight from carry_i
                grp_carry[0] = carry_i;
                for (int i = 1; i <= GRPS; i++) begin
                        acc  = 1'b0;
                        span = 1'b1;
                        for (int j = i - 1; j >= 0; j--) begin
                                acc  = acc | (span & grp_gen[j]);
                                span = span & grp_prop[j];
                        end
                        grp_carry[i] = acc | (span & carry_i);
                end
                // Bit carries inside each group
                for (int g = 0; g < GRPS; g++) begin
                        for (int k = 0; k < 4; k++) begin
                                acc  = 1'b0;
                                span = 1'b1;
                                for (int j = k - 1; j >= 0; j--) begin
                                        acc  = acc | (span & gen[4*g+j]);
                                        span = span & prop[4*g+j];
                                end
                                bit_carry[4*g+k] = acc | (span & grp_carry[g]);
                        end
                end
        end

        assign result_o = prop ^ bit_carry;
        assign carry_o  = grp_carry[GRPS];

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
        parameter int NUM_REGS = 32
) (
        input  logic                        clk_i,
        input  logic                        reset_i,
        input  logic                        instr_valid_i,
        input  logic [31:0]                 instr_i,
        output logic                        wb_valid_o,
        output logic [4:0]                  wb_rd_o,
        output logic [rv_alu_pkg::XLEN-1:0] wb_data_o
);
        import rv_alu_pkg::*;

        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;

        alu_req_if req_if ();

        instr_decoder #(
                .NUM_REGS (NUM_REGS)
        ) i_decoder (
                .clk_i         (clk_i),
                .reset_i       (reset_i),
                .instr_valid_i (instr_valid_i),
                .instr_i       (instr_i),
                .rs1_addr_o    (rs1_addr),
                .rs2_addr_o    (rs2_addr),
                .rs1_data_i    (rs1_data),
                .rs2_data_i    (rs2_data),
                .req           (req_if.decoder)
        );

        reg_file #(
                .NUM_REGS (NUM_REGS)
        ) i_reg_file (
                .clk_i      (clk_i),
                .reset_i    (reset_i),
                .rs1_addr_i (rs1_addr),
                .rs2_addr_i (rs2_addr),
                .rs1_data_o (rs1_data),
                .rs2_data_o (rs2_data),
                .wr_en_i    (wb_valid_o),               // Writeback doubles as write port
                .wr_addr_i  (wb_rd_o),
                .wr_data_i  (wb_data_o)
        );

        alu i_alu (
                .clk_i     (clk_i),
                .reset_i   (reset_i),
                .req       (req_if.alu),
                .wr_en_o   (wb_valid_o),
                .wr_addr_o (wb_rd_o),
                .wr_data_o (wb_data_o)
        );

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder #(
        parameter int NUM_REGS = 32
) (
        input  logic                        clk_i,
        input  logic                        reset_i,
        input  logic                        instr_valid_i,
        input  rv_alu_pkg::instr_u          instr_i,
        output logic [4:0]                  rs1_addr_o,
        output logic [4:0]                  rs2_addr_o,
        input  logic [rv_alu_pkg::XLEN-1:0] rs1_data_i,
        input  logic [rv_alu_pkg::XLEN-1:0] rs2_data_i,
        alu_req_if.decoder                  req
);
        import rv_alu_pkg::*;

        logic            is_op;
        logic            alt_op;
        alu_op_e         op_d;
        unit_sel_e       unit_d;
        logic            use_imm_d;
        logic [XLEN-1:0] imm_d;
        logic [4:0]      rs1_d;
        logic [4:0]      rs2_d;
        logic            use_imm_q;
        logic [XLEN-1:0] imm_q;

        assign is_op  = (instr_i.r_fmt.opcode == OPC_OP);
        assign alt_op = instr_i.r_fmt.funct7[5];        // Bit 30 of the word

        always_comb begin
                unit_d    = UNIT_ALU;
                use_imm_d = 1'b1;
                imm_d     = {{(XLEN-12){instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
                rs1_d     = instr_i.r_fmt.rs1;
                rs2_d     = instr_i.r_fmt.rs2;
                case (instr_i.r_fmt.funct3)
                3'b000:  op_d = (is_op && alt_op) ? ALU_SUB : ALU_ADD;
                3'b001:  op_d = ALU_SLL;
                3'b010:  op_d = ALU_SLT;
                3'b011:  op_d = ALU_SLTU;
                3'b100:  op_d = (is_op && alt_op) ? ALU_XNOR : ALU_XOR;
                3'b101:  op_d = alt_op ? ALU_SRA : ALU_SRL;     // Same bit in shift-imm
                3'b110:  op_d = ALU_OR;
                default: op_d = ALU_AND;
                endcase
                case (instr_i.r_fmt.opcode)
                OPC_OP: begin
                        use_imm_d = 1'b0;
                end
                OPC_OP_IMM: begin
                        rs2_d = '0;                     // Field is immediate bits
                end
                OPC_LUI: begin
                        op_d  = ALU_LUI;
                        imm_d = {instr_i.u_fmt.imm20, 12'b0};
                        rs1_d = '0;
                        rs2_d = '0;
                end
                default: begin
                        unit_d = UNIT_NONE;
                        rs1_d  = '0;
                        rs2_d  = '0;
                end
                endcase
        end

        // Request register
        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        req.valid  <= 1'b0;
                        rs1_addr_o <= '0;
                        rs2_addr_o <= '0;
                end else begin
                        req.valid <= instr_valid_i;
                        if (instr_valid_i) begin
                                rs1_addr_o   <= rs1_d;
                                rs2_addr_o   <= rs2_d;
                                req.op       <= op_d;
                                req.unit_sel <= unit_d;
                                req.rd       <= instr_i.r_fmt.rd;
                                use_imm_q    <= use_imm_d;
                                imm_q        <= imm_d;
                        end
                end
        end

        // Operands read during the ALU cycle through the bypass
        assign req.operand_a = rs1_data_i;
        assign req.operand_b = use_imm_q ? imm_q : rs2_data_i;

        a_src_range: assert property (@(posedge clk_i) disable iff (reset_i)
                req.valid |-> (rs1_addr_o < NUM_REGS) && (rs2_addr_o < NUM_REGS));

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
        parameter int NUM_REGS = 32
) (
        input  logic                        clk_i,
        input  logic                        reset_i,
        input  logic [4:0]                  rs1_addr_i,
        input  logic [4:0]                  rs2_addr_i,
        output logic [rv_alu_pkg::XLEN-1:0] rs1_data_o,
        output logic [rv_alu_pkg::XLEN-1:0] rs2_data_o,
        input  logic                        wr_en_i,
        input  logic [4:0]                  wr_addr_i,
        input  logic [rv_alu_pkg::XLEN-1:0] wr_data_i
);
        import rv_alu_pkg::*;

        logic [XLEN-1:0] regs [NUM_REGS];
        logic            wr_live;
        logic            hit1;
        logic            hit2;

        assign wr_live = wr_en_i && (wr_addr_i != 5'd0);        // x0 stays zero

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_live) begin
                        regs[wr_addr_i] <= wr_data_i;
                end
        end

        // Write-first bypass
        assign hit1 = wr_live && (wr_addr_i == rs1_addr_i);
        assign hit2 = wr_live && (wr_addr_i == rs2_addr_i);

        assign rs1_data_o = hit1 ? wr_data_i : regs[rs1_addr_i];
        assign rs2_data_o = hit2 ? wr_data_i : regs[rs2_addr_i];

        a_wr_range: assert property (@(posedge clk_i) disable iff (reset_i)
                wr_en_i |-> wr_addr_i < NUM_REGS);

endmodule

/* rv_alu_pkg.sv */
package rv_alu_pkg;

        localparam int unsigned XLEN = 32;

        typedef enum logic [3:0] {
                ALU_ADD  = 4'b0000,
                ALU_SUB  = 4'b0001,
                ALU_SLL  = 4'b0011,
                ALU_SLT  = 4'b0100,
                ALU_SLTU = 4'b0101,
                ALU_XOR  = 4'b0110,
                ALU_SRL  = 4'b0111,
                ALU_SRA  = 4'b1000,
                ALU_OR   = 4'b1001,
                ALU_AND  = 4'b1010,
                ALU_XNOR = 4'b1011,
                ALU_LUI  = 4'b1100
        } alu_op_e;

        typedef enum logic [1:0] {
                UNIT_ALU  = 2'b00,
                UNIT_NONE = 2'b01                       // Anything the ALU does not take
        } unit_sel_e;

        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_LUI    = 7'b0110111;

        // One instruction word in three field layouts
        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } r_fmt;
                struct packed {
                        logic [11:0] imm12;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i_fmt;
                struct packed {
                        logic [19:0] imm20;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } u_fmt;
        } instr_u;

endpackage

/* tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit;

        localparam int MAX_CYCLES  = 2000;              // Tests need about 450
        localparam int DRAIN_LIMIT = 8;                 // Two-edge latency plus margin

        logic        clk_i;
        logic        reset_i;
        logic        instr_valid_i;
        logic [31:0] instr_i;
        logic        wb_valid_o;
        logic [4:0]  wb_rd_o;
        logic [31:0] wb_data_o;

        logic [31:0] regs_m [32];                       // Model register file
        logic [36:0] exp_q [$];                         // {rd, data} in issue order
        logic [36:0] wb_exp;
        string       cur_test;
        int          cycles = 0;

        exec_unit #(
                .NUM_REGS (32)
        ) i_exec_unit (
                .clk_i         (clk_i),
                .reset_i       (reset_i),
                .instr_valid_i (instr_valid_i),
                .instr_i       (instr_i),
                .wb_valid_o    (wb_valid_o),
                .wb_rd_o       (wb_rd_o),
                .wb_data_o     (wb_data_o)
        );

        always #20 clk_i = ~clk_i;

        task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
                if (exp !== act) begin
                        $display("ERR %s %s: expected %08h, actual %08h",
                                 cur_test, what, exp, act);
                        $display("sim failed");
                        $fatal(1, "stopping at first mismatch");
                end
        endtask

        function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
        endfunction

        function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
                return {imm, rs1, f3, rd, 7'b0010011};
        endfunction

        function automatic logic [31:0] u_word(input logic [4:0] rd, input logic [19:0] imm);
                return {imm, rd, 7'b0110111};
        endfunction

        // SUB and XNOR only exist in register form
        function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                                  input logic reg_form, input logic [31:0] a,
                                                  input logic [31:0] b);
                case (f3)
                3'b000:  return (reg_form && alt) ? a - b : a + b;
                3'b001:  return a << b[4:0];
                3'b010:  return {31'b0, $signed(a) < $signed(b)};
                3'b011:  return {31'b0, a < b};
                3'b100:  return (reg_form && alt) ? ~(a ^ b) : a ^ b;
                3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  return a | b;
                default: return a & b;
                endcase
        endfunction

        function automatic logic [4:0] rand_reg();
                logic [31:0] r;
                r = $urandom_range(31, 1);
                return r[4:0];
        endfunction

        task automatic expect_wb(input logic [4:0] rd, input logic [31:0] val);
                exp_q.push_back({rd, val});
                if (rd != 5'd0) begin
                        regs_m[rd] = val;               // x0 never changes
                end
        endtask

        task automatic issue(input logic [31:0] word);
                @(posedge clk_i);
                instr_valid_i <= 1'b1;
                instr_i       <= word;
        endtask

        task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
                logic [31:0] res;
                res = model_alu(f3, f7[5], 1'b1, regs_m[rs1], regs_m[rs2]);
                expect_wb(rd, res);
                issue(r_word(f7, f3, rd, rs1, rs2));
        endtask

        task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [11:0] imm);
                logic [31:0] res;
                res = model_alu(f3, imm[10], 1'b0, regs_m[rs1], {{20{imm[11]}}, imm});
                expect_wb(rd, res);
                issue(i_word(f3, rd, rs1, imm));
        endtask

        task automatic lui_op(input logic [4:0] rd, input logic [19:0] imm);
                expect_wb(rd, {imm, 12'b0});
                issue(u_word(rd, imm));
        endtask

        // ADDI sign-extends, so the upper part absorbs bit 11
        task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
                lui_op(rd, val[31:12] + {19'b0, val[11]});
                imm_op(3'b000, rd, rd, val[11:0]);
        endtask

        task automatic drain();
                int n;
                n = 0;
                @(posedge clk_i);
                instr_valid_i <= 1'b0;
                while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
                        @(posedge clk_i);
                        n++;
                end
                if (exp_q.size() != 0) begin
                        $display("%s ended with %0d writebacks never seen",
                                 cur_test, exp_q.size());
                        $display("sim failed");
                        $fatal(1, "missing writeback");
                end
        endtask

        // Writebacks compared at the falling edge
        always @(negedge clk_i) begin
                if (!reset_i && wb_valid_o) begin
                        if (exp_q.size() == 0) begin
                                $display("%s: writeback strobe with nothing expected", cur_test);
                                $display("sim failed");
                                $fatal(1, "unexpected writeback");
                        end
                        wb_exp = exp_q.pop_front();
                        check("wb_rd", {27'b0, wb_exp[36:32]}, {27'b0, wb_rd_o});
                        check("wb_data", wb_exp[31:0], wb_data_o);
                end
        end

        always @(posedge clk_i) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout after %0d cycles in %s", cycles, cur_test);
                        $display("sim failed");
                        $fatal(1, "run did not finish");
                end
        end

        task automatic reset_state();
                cur_test = "reset_state";
                @(negedge clk_i);
                check("wb_valid", 32'd0, {31'b0, wb_valid_o});
                check("wb_data", 32'd0, wb_data_o);
                for (int i = 0; i < 32; i++) begin
                        imm_op(3'b000, 5'(i), 5'(i), 12'h000);  // Reads each reset value
                end
                drain();
        endtask

        task automatic load_constants();
                logic [31:0] v;
                logic [31:0] r;
                logic [4:0]  rd;
                cur_test = "load_constants";
                for (int k = 0; k < 10; k++) begin
                        rd = rand_reg();
                        v  = $urandom;
                        v[11] = (k % 2 == 0);           // Half with a negative low part
                        load_reg(rd, v);
                        r = $urandom;
                        imm_op(3'b000, rand_reg(), rd, {1'b1, r[10:0]});
                end
                r = $urandom;
                lui_op(5'd0, r[19:0]);                  // Strobe still pulses for x0
                imm_op(3'b000, 5'd0, rd, r[31:20]);
                imm_op(3'b000, 5'd9, 5'd0, 12'h000);
                reg_op(7'h00, 3'b000, 5'd10, 5'd0, 5'd0);
                drain();
        endtask

        task automatic reg_arith();
                logic [9:0]  ops [8];
                logic [31:0] r;
                cur_test = "reg_arith";
                ops = '{{7'h00, 3'b000}, {7'h20, 3'b000}, {7'h00, 3'b010}, {7'h00, 3'b011},
                        {7'h00, 3'b100}, {7'h20, 3'b100}, {7'h00, 3'b110}, {7'h00, 3'b111}};
                for (int i = 1; i < 32; i++) begin
                        load_reg(5'(i), $urandom);
                end
                for (int k = 0; k < 100; k++) begin
                        r = $urandom_range(7, 0);
                        reg_op(ops[r[2:0]][9:3], ops[r[2:0]][2:0], rand_reg(),
                               5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
                end
                drain();
        endtask

        task automatic shift_ops();
                logic [4:0]  amounts [6];
                logic [31:0] v;
                cur_test = "shift_ops";
                amounts[0] = 5'd0;
                amounts[1] = 5'd31;
                amounts[2] = 5'($urandom_range(30, 1));
                amounts[3] = 5'($urandom_range(30, 1));
                amounts[4] = 5'($urandom_range(30, 1));
                amounts[5] = 5'd1;
                load_reg(5'd1, 32'h8765_4321);
                load_reg(5'd2, 32'h1234_5678);
                for (int k = 0; k < 6; k++) begin
                        v      = $urandom;              // Upper bits must be ignored
                        v[4:0] = amounts[k];
                        load_reg(5'd3, v);
                        for (int s = 1; s <= 2; s++) begin
                                reg_op(7'h00, 3'b001, 5'd4, 5'(s), 5'd3);
                                reg_op(7'h00, 3'b101, 5'd5, 5'(s), 5'd3);
                                reg_op(7'h20, 3'b101, 5'd6, 5'(s), 5'd3);
                                imm_op(3'b001, 5'd7, 5'(s), {7'h00, amounts[k]});
                                imm_op(3'b101, 5'd8, 5'(s), {7'h00, amounts[k]});
                                imm_op(3'b101, 5'd9, 5'(s), {7'h20, amounts[k]});
                        end
                end
                drain();
        endtask

        task automatic dep_chain();
                logic [4:0]  prev;
                logic [4:0]  nxt;
                logic [31:0] r;
                cur_test = "dep_chain";
                load_reg(5'd1, $urandom);
                load_reg(5'd2, $urandom);
                prev = 5'd1;
                for (int k = 0; k < 40; k++) begin
                        nxt = (prev >= 5'd31 || prev < 5'd3) ? 5'd3 : prev + 5'd1;
                        r   = $urandom;
                        case (r[31:30])
                        2'd0:    imm_op(3'b000, nxt, prev, r[11:0]);
                        2'd1:    reg_op(7'h20, 3'b000, nxt, 5'd2, prev);
                        2'd2:    reg_op(7'h20, 3'b100, nxt, prev, 5'd2);
                        default: imm_op(3'b101, nxt, prev, {7'h20, r[4:0]});
                        endcase
                        prev = nxt;
                end
                drain();
        endtask

        task automatic unsupported_opcode();
                logic [31:0] word;
                cur_test = "unsupported_opcode";
                imm_op(3'b000, 5'd7, 5'd0, 12'h123);
                drain();
                word      = $urandom;
                word[6:0] = 7'b0100011;                 // Store
                issue(word);
                @(posedge clk_i);
                instr_valid_i <= 1'b0;
                repeat (4) begin
                        @(negedge clk_i);
                        check("wb_valid", 32'd0, {31'b0, wb_valid_o});
                        check("held wb_data", 32'h0000_0123, wb_data_o);
                end
                issue(word);
                imm_op(3'b000, 5'd8, 5'd7, 12'h001);
                drain();
        endtask

        initial begin
                void'($urandom(73));
                clk_i         = 1'b0;
                reset_i       = 1'b1;
                instr_valid_i = 1'b0;
                instr_i       = 32'b0;
                cur_test      = "reset";
                for (int i = 0; i < 32; i++) begin
                        regs_m[i] = 32'b0;
                end
                repeat (10) @(posedge clk_i);
                reset_i <= 1'b0;
                reset_state();
                load_constants();
                reg_arith();
                shift_ops();
                dep_chain();
                unsupported_opcode();
                repeat (4) @(posedge clk_i);
                if (exp_q.size() != 0) begin
                        $display("%0d writebacks left over at end of run", exp_q.size());
                        $display("sim failed");
                        $fatal(1, "leftover writebacks");
                end else begin
                        $display("sim passed");
                        $finish;
                end
        end

endmodule

/* vlog.f */
rv_alu_pkg.sv
alu_req_if.sv
cla_32bit.sv
alu.sv
instr_decoder.sv
reg_file.sv
exec_unit.sv
tb_exec_unit.sv
